// File: Makefile
VERILATOR ?= verilator
TOP       ?= ntm_scalar_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= test passed

BIN     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(FILELIST) $(wildcard include/*.svh src/*.sv verif/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the result"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

$(BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)

# Exit status comes from the search for the pass line
test: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: all.f
+incdir+include
src/ntm_arithmetic_pkg.sv
src/ntm_scalar_if.sv
src/ntm_scalar_fixed_adder.sv
src/ntm_scalar_fixed_multiplier.sv
src/ntm_scalar_fixed_divider.sv
src/ntm_scalar_fixed_unit.sv
verif/ntm_scalar_asserts.sv
verif/ntm_scalar_tb.sv

// File: include/ntm_scalar_cfg.svh
`ifndef NTM_SCALAR_CFG_SVH
`define NTM_SCALAR_CFG_SVH

// Operand and result width in bits
`define NTM_DATA_SIZE 32

// Fraction bits of the Q format
// Integer part is NTM_DATA_SIZE - NTM_FRACTION_SIZE bits, sign included
`define NTM_FRACTION_SIZE 16

// Operation code width
`define NTM_OP_SIZE 2

`endif

// File: src/ntm_arithmetic_pkg.sv
`include "ntm_scalar_cfg.svh"

package ntm_arithmetic_pkg;

  //////////////////////////////////////////////////////////////////////
  // Data types
  //////////////////////////////////////////////////////////////////////

  // Signed fixed-point value, two's complement
  typedef logic signed [`NTM_DATA_SIZE-1:0] data_t;

  // Operation select from the host
  typedef enum logic [`NTM_OP_SIZE-1:0] {
    OP_ADD,
    OP_SUB,
    OP_MUL,
    OP_DIV
  } op_e;

  // Divider FSM
  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_ITERATE,
    DIV_FINISH
  } div_state_e;

  //////////////////////////////////////////////////////////////////////
  // Saturation limits
  //////////////////////////////////////////////////////////////////////

  // Most positive value
  localparam data_t DATA_MAX = {1'b0, {(`NTM_DATA_SIZE-1){1'b1}}};
  // Most negative value
  localparam data_t DATA_MIN = {1'b1, {(`NTM_DATA_SIZE-1){1'b0}}};

endpackage

// File: src/ntm_scalar_fixed_adder.sv
`timescale 1ns/1ps

`include "ntm_scalar_cfg.svh"

module ntm_scalar_fixed_adder (
  input  logic CLK,
  input  logic RST,
  input  logic subtract,
  ntm_scalar_if.unit port
);

  localparam int DATA_SIZE = `NTM_DATA_SIZE;

  //////////////////////////////////////////////////////////////////////
  // Widened sum
  //////////////////////////////////////////////////////////////////////

  // One guard bit above the sign
  logic [DATA_SIZE:0] a_ext;
  logic [DATA_SIZE:0] b_ext;
  logic [DATA_SIZE:0] sum_wide;

  logic                      sum_ovf;
  ntm_arithmetic_pkg::data_t sum_sat;

  assign a_ext = {port.data_a[DATA_SIZE-1], port.data_a};
  assign b_ext = {port.data_b[DATA_SIZE-1], port.data_b};

  always_comb begin
    if (subtract) begin
      sum_wide = a_ext - b_ext;
    end else begin
      sum_wide = a_ext + b_ext;
    end
  end

  // Guard and sign disagree when the result left the range
  assign sum_ovf = sum_wide[DATA_SIZE] ^ sum_wide[DATA_SIZE-1];

  // Guard bit holds the true sign, so it picks the limit
  always_comb begin
    if (!sum_ovf) begin
      sum_sat = sum_wide[DATA_SIZE-1:0];
    end else if (sum_wide[DATA_SIZE]) begin
      sum_sat = ntm_arithmetic_pkg::DATA_MIN;
    end else begin
      sum_sat = ntm_arithmetic_pkg::DATA_MAX;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Result register
  //////////////////////////////////////////////////////////////////////

  // Strobe and flag
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      port.ready    <= 1'b0;
      port.overflow <= 1'b0;
    end else begin
      port.ready <= port.start;
      if (port.start) begin
        port.overflow <= sum_ovf;
      end
    end
  end

  // Value, held until the next job
  always_ff @(posedge CLK) begin
    if (port.start) begin
      port.data_out <= sum_sat;
    end
  end

endmodule

// File: src/ntm_scalar_fixed_divider.sv
`timescale 1ns/1ps

`include "ntm_scalar_cfg.svh"

module ntm_scalar_fixed_divider (
  input  logic CLK,
  input  logic RST,
  ntm_scalar_if.unit port
);

  localparam int DATA_SIZE = `NTM_DATA_SIZE;
  localparam int FRAC_SIZE = `NTM_FRACTION_SIZE;
  // Dividend is |A| with FRAC_SIZE zeros appended
  localparam int DVD_SIZE  = `NTM_DATA_SIZE + `NTM_FRACTION_SIZE;
  localparam int CNT_SIZE  = $clog2(DVD_SIZE + 1);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  ntm_arithmetic_pkg::div_state_e state_r;
  logic [CNT_SIZE-1:0]            cnt_r;

  // Datapath
  logic [DVD_SIZE-1:0]  dvd_r;
  logic [DATA_SIZE-1:0] dvs_r;
  logic [DATA_SIZE-1:0] rem_r;
  logic [DVD_SIZE-1:0]  quo_r;
  logic                 neg_r;

  // Operand magnitudes, MIN maps to 2^(DATA_SIZE-1) unsigned
  logic [DATA_SIZE-1:0] mag_a;
  logic [DATA_SIZE-1:0] mag_b;
  logic                 div_zero;

  // One restoring step
  logic [DATA_SIZE:0]   rem_shift;
  logic                 q_bit;
  logic [DATA_SIZE-1:0] rem_next;

  // Final signed result
  logic [DATA_SIZE-1:0]      quo_low;
  logic                      quo_ovf;
  ntm_arithmetic_pkg::data_t quo_sat;

  //////////////////////////////////////////////////////////////////////
  // Combinational datapath
  //////////////////////////////////////////////////////////////////////

  assign mag_a = port.data_a[DATA_SIZE-1] ? (~port.data_a + 1'b1) : port.data_a;
  assign mag_b = port.data_b[DATA_SIZE-1] ? (~port.data_b + 1'b1) : port.data_b;
  assign div_zero = (port.data_b == '0);

  // Next dividend bit enters the partial remainder
  assign rem_shift = {rem_r, dvd_r[DVD_SIZE-1]};
  assign q_bit     = (rem_shift >= {1'b0, dvs_r});

  // Keep the old remainder when the trial subtraction fails
  always_comb begin
    if (q_bit) begin
      rem_next = DATA_SIZE'(rem_shift - {1'b0, dvs_r});
    end else begin
      rem_next = rem_shift[DATA_SIZE-1:0];
    end
  end

  assign quo_low = quo_r[DATA_SIZE-1:0];

  // Negative side reaches one step further than the positive side
  always_comb begin
    if (neg_r) begin
      quo_ovf = (|quo_r[DVD_SIZE-1:DATA_SIZE]) ||
                (quo_r[DATA_SIZE-1] && (|quo_r[DATA_SIZE-2:0]));
    end else begin
      quo_ovf = |quo_r[DVD_SIZE-1:DATA_SIZE-1];
    end
  end

  // Truncation toward zero, sign applied after the magnitude division
  always_comb begin
    if (quo_ovf) begin
      quo_sat = neg_r ? ntm_arithmetic_pkg::DATA_MIN : ntm_arithmetic_pkg::DATA_MAX;
    end else if (neg_r) begin
      quo_sat = ~quo_low + 1'b1;
    end else begin
      quo_sat = quo_low;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_r       <= ntm_arithmetic_pkg::DIV_IDLE;
      cnt_r         <= '0;
      port.ready    <= 1'b0;
      port.overflow <= 1'b0;
    end else begin
      port.ready <= 1'b0;
      case (state_r)
        ntm_arithmetic_pkg::DIV_IDLE: begin
          if (port.start) begin
            if (div_zero) begin
              // Zero divisor answers at once
              port.ready    <= 1'b1;
              port.overflow <= 1'b1;
            end else begin
              cnt_r   <= CNT_SIZE'(DVD_SIZE);
              state_r <= ntm_arithmetic_pkg::DIV_ITERATE;
            end
          end
        end
        ntm_arithmetic_pkg::DIV_ITERATE: begin
          // One quotient bit per cycle
          cnt_r <= cnt_r - 1'b1;
          if (cnt_r == CNT_SIZE'(1)) begin
            state_r <= ntm_arithmetic_pkg::DIV_FINISH;
          end
        end
        ntm_arithmetic_pkg::DIV_FINISH: begin
          port.ready    <= 1'b1;
          port.overflow <= quo_ovf;
          state_r       <= ntm_arithmetic_pkg::DIV_IDLE;
        end
        default: begin
          state_r <= ntm_arithmetic_pkg::DIV_IDLE;
        end
      endcase
    end
  end

  // Datapath registers follow the FSM
  always_ff @(posedge CLK) begin
    case (state_r)
      ntm_arithmetic_pkg::DIV_IDLE: begin
        if (port.start) begin
          if (div_zero) begin
            port.data_out <= ntm_arithmetic_pkg::DATA_MAX;
          end else begin
            dvd_r <= {mag_a, {FRAC_SIZE{1'b0}}};
            dvs_r <= mag_b;
            rem_r <= '0;
            quo_r <= '0;
            neg_r <= port.data_a[DATA_SIZE-1] ^ port.data_b[DATA_SIZE-1];
          end
        end
      end
      ntm_arithmetic_pkg::DIV_ITERATE: begin
        dvd_r <= dvd_r << 1;
        rem_r <= rem_next;
        quo_r <= {quo_r[DVD_SIZE-2:0], q_bit};
      end
      ntm_arithmetic_pkg::DIV_FINISH: begin
        port.data_out <= quo_sat;
      end
      default: begin
        rem_r <= '0;
      end
    endcase
  end

endmodule

// File: src/ntm_scalar_fixed_multiplier.sv
`timescale 1ns/1ps

`include "ntm_scalar_cfg.svh"

module ntm_scalar_fixed_multiplier (
  input  logic CLK,
  input  logic RST,
  ntm_scalar_if.unit port
);

  localparam int DATA_SIZE = `NTM_DATA_SIZE;
  localparam int FRAC_SIZE = `NTM_FRACTION_SIZE;
  localparam int PROD_SIZE = 2 * `NTM_DATA_SIZE;

  //////////////////////////////////////////////////////////////////////
  // Stage one, full product
  //////////////////////////////////////////////////////////////////////

  // Sign extended operands so the product keeps every bit
  logic signed [PROD_SIZE-1:0] a_wide;
  logic signed [PROD_SIZE-1:0] b_wide;
  logic signed [PROD_SIZE-1:0] product_r;
  logic                        valid_r;

  assign a_wide = {{DATA_SIZE{port.data_a[DATA_SIZE-1]}}, port.data_a};
  assign b_wide = {{DATA_SIZE{port.data_b[DATA_SIZE-1]}}, port.data_b};

  always_ff @(posedge CLK) begin
    if (port.start) begin
      product_r <= a_wide * b_wide;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stage two, rescale and saturate
  //////////////////////////////////////////////////////////////////////

  // Arithmetic shift drops the extra fraction bits, floor rounding
  logic signed [PROD_SIZE-1:0] scaled;
  logic                        scaled_ovf;
  ntm_arithmetic_pkg::data_t   scaled_sat;

  assign scaled = product_r >>> FRAC_SIZE;

  // Fits only when all bits above the result sign copy it
  assign scaled_ovf = !((&scaled[PROD_SIZE-1:DATA_SIZE-1]) ||
                        (~|scaled[PROD_SIZE-1:DATA_SIZE-1]));

  always_comb begin
    if (!scaled_ovf) begin
      scaled_sat = scaled[DATA_SIZE-1:0];
    end else if (product_r[PROD_SIZE-1]) begin
      scaled_sat = ntm_arithmetic_pkg::DATA_MIN;
    end else begin
      scaled_sat = ntm_arithmetic_pkg::DATA_MAX;
    end
  end

  // Pipeline control, two jobs may be in flight
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      valid_r       <= 1'b0;
      port.ready    <= 1'b0;
      port.overflow <= 1'b0;
    end else begin
      valid_r    <= port.start;
      port.ready <= valid_r;
      if (valid_r) begin
        port.overflow <= scaled_ovf;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (valid_r) begin
      port.data_out <= scaled_sat;
    end
  end

endmodule

// File: src/ntm_scalar_fixed_unit.sv
`timescale 1ns/1ps

module ntm_scalar_fixed_unit (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      START,
  input  ntm_arithmetic_pkg::op_e   OPERATION,
  input  ntm_arithmetic_pkg::data_t DATA_A_IN,
  input  ntm_arithmetic_pkg::data_t DATA_B_IN,
  output logic                      READY,
  output logic                      BUSY,
  output ntm_arithmetic_pkg::data_t DATA_OUT,
  output logic                      OVERFLOW_OUT
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  logic                      accept;
  logic                      start_q;
  ntm_arithmetic_pkg::op_e   op_q;
  ntm_arithmetic_pkg::data_t a_q;
  ntm_arithmetic_pkg::data_t b_q;

  // Selected block result
  logic                      blk_ready;
  ntm_arithmetic_pkg::data_t blk_data;
  logic                      blk_ovf;

  // One link per arithmetic block
  ntm_scalar_if add_if ();
  ntm_scalar_if mul_if ();
  ntm_scalar_if div_if ();

  //////////////////////////////////////////////////////////////////////
  // Accept and dispatch
  //////////////////////////////////////////////////////////////////////

  // Only idle unit takes a job
  assign accept = START && !BUSY;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      BUSY    <= 1'b0;
      start_q <= 1'b0;
      op_q    <= ntm_arithmetic_pkg::OP_ADD;
    end else begin
      start_q <= accept;
      if (accept) begin
        BUSY <= 1'b1;
        op_q <= OPERATION;
      end else if (READY) begin
        // Busy covers the result cycle too
        BUSY <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      a_q <= DATA_A_IN;
      b_q <= DATA_B_IN;
    end
  end

  // Start goes to one block only
  assign add_if.start = start_q && ((op_q == ntm_arithmetic_pkg::OP_ADD) ||
                                    (op_q == ntm_arithmetic_pkg::OP_SUB));
  assign mul_if.start = start_q && (op_q == ntm_arithmetic_pkg::OP_MUL);
  assign div_if.start = start_q && (op_q == ntm_arithmetic_pkg::OP_DIV);

  assign add_if.data_a = a_q;
  assign add_if.data_b = b_q;
  assign mul_if.data_a = a_q;
  assign mul_if.data_b = b_q;
  assign div_if.data_a = a_q;
  assign div_if.data_b = b_q;

  //////////////////////////////////////////////////////////////////////
  // Arithmetic blocks
  //////////////////////////////////////////////////////////////////////

  ntm_scalar_fixed_adder u_adder (
    .CLK      (CLK),
    .RST      (RST),
    .subtract (op_q == ntm_arithmetic_pkg::OP_SUB),
    .port     (add_if.unit)
  );

  ntm_scalar_fixed_multiplier u_multiplier (
    .CLK  (CLK),
    .RST  (RST),
    .port (mul_if.unit)
  );

  ntm_scalar_fixed_divider u_divider (
    .CLK  (CLK),
    .RST  (RST),
    .port (div_if.unit)
  );

  //////////////////////////////////////////////////////////////////////
  // Result mux and output register
  //////////////////////////////////////////////////////////////////////

  // Latched op holds for the whole job
  always_comb begin
    case (op_q)
      ntm_arithmetic_pkg::OP_ADD, ntm_arithmetic_pkg::OP_SUB: begin
        blk_ready = add_if.ready;
        blk_data  = add_if.data_out;
        blk_ovf   = add_if.overflow;
      end
      ntm_arithmetic_pkg::OP_MUL: begin
        blk_ready = mul_if.ready;
        blk_data  = mul_if.data_out;
        blk_ovf   = mul_if.overflow;
      end
      default: begin
        blk_ready = div_if.ready;
        blk_data  = div_if.data_out;
        blk_ovf   = div_if.overflow;
      end
    endcase
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      READY        <= 1'b0;
      DATA_OUT     <= '0;
      OVERFLOW_OUT <= 1'b0;
    end else begin
      READY <= blk_ready;
      if (blk_ready) begin
        DATA_OUT     <= blk_data;
        OVERFLOW_OUT <= blk_ovf;
      end
    end
  end

endmodule

// File: src/ntm_scalar_if.sv
`timescale 1ns/1ps

interface ntm_scalar_if;

  // Job strobe from the top level, one cycle
  logic                      start;
  // Result strobe from the block, one cycle
  logic                      ready;

  // Operands, stable from start onwards
  ntm_arithmetic_pkg::data_t data_a;
  ntm_arithmetic_pkg::data_t data_b;

  // Result, held until the next one
  ntm_arithmetic_pkg::data_t data_out;
  logic                      overflow;

  // Arithmetic block side
  modport unit (
    input  start, data_a, data_b,
    output ready, data_out, overflow
  );

  // Dispatcher side
  modport host (
    output start, data_a, data_b,
    input  ready, data_out, overflow
  );

endinterface

// File: verif/ntm_scalar_asserts.sv
`timescale 1ns/1ps

module ntm_scalar_asserts (
  input logic                      CLK,
  input logic                      RST,
  input logic                      START,
  input logic                      READY,
  input logic                      BUSY,
  input logic                      OVERFLOW_OUT,
  input ntm_arithmetic_pkg::op_e   op_q,
  input ntm_arithmetic_pkg::data_t a_q,
  input ntm_arithmetic_pkg::data_t b_q
);

  // Result strobe is a single cycle pulse
  ready_pulse: assert property (@(posedge CLK) disable iff (RST) READY |=> !READY)
    else $error("READY stayed high for more than one cycle");

  // No result without a job in progress
  ready_in_busy: assert property (@(posedge CLK) disable iff (RST) READY |-> BUSY)
    else $error("READY pulsed while BUSY was low");

  // Flag must be driven with the result
  ovf_known: assert property (@(posedge CLK) disable iff (RST)
                              READY |-> !$isunknown(OVERFLOW_OUT))
    else $error("OVERFLOW_OUT unknown during READY");

  // Dropped start leaves the latched job alone
  drop_holds_job: assert property (@(posedge CLK) disable iff (RST)
                                   (START && BUSY) |=>
                                   ($stable(op_q) && $stable(a_q) && $stable(b_q)))
    else $error("START during BUSY changed the latched job");

  // and keeps the unit busy until the result
  drop_holds_busy: assert property (@(posedge CLK) disable iff (RST)
                                    (START && BUSY && !READY) |=> BUSY)
    else $error("START during BUSY released BUSY early");

endmodule

bind ntm_scalar_fixed_unit ntm_scalar_asserts u_asserts (
  .CLK          (CLK),
  .RST          (RST),
  .START        (START),
  .READY        (READY),
  .BUSY         (BUSY),
  .OVERFLOW_OUT (OVERFLOW_OUT),
  .op_q         (op_q),
  .a_q          (a_q),
  .b_q          (b_q)
);

// File: verif/ntm_scalar_tb.sv
`timescale 1ns/1ps

`include "ntm_scalar_cfg.svh"

module ntm_scalar_tb;

  localparam int FRAC    = `NTM_FRACTION_SIZE;
  // Cycles allowed for one READY, divide is about 52
  localparam int TIMEOUT = 200;
  // Watch window for stray pulses
  localparam int QUIET   = 64;

  localparam ntm_arithmetic_pkg::op_e ADD = ntm_arithmetic_pkg::OP_ADD;
  localparam ntm_arithmetic_pkg::op_e SUB = ntm_arithmetic_pkg::OP_SUB;
  localparam ntm_arithmetic_pkg::op_e MUL = ntm_arithmetic_pkg::OP_MUL;
  localparam ntm_arithmetic_pkg::op_e DIV = ntm_arithmetic_pkg::OP_DIV;

  localparam ntm_arithmetic_pkg::data_t MAX = ntm_arithmetic_pkg::DATA_MAX;
  localparam ntm_arithmetic_pkg::data_t MIN = ntm_arithmetic_pkg::DATA_MIN;
  localparam longint MAX_L = longint'(ntm_arithmetic_pkg::DATA_MAX);
  localparam longint MIN_L = longint'(ntm_arithmetic_pkg::DATA_MIN);

  logic                      CLK;
  logic                      RST;
  logic                      start;
  ntm_arithmetic_pkg::op_e   operation;
  ntm_arithmetic_pkg::data_t data_a;
  ntm_arithmetic_pkg::data_t data_b;
  logic                      ready;
  logic                      busy;
  ntm_arithmetic_pkg::data_t data_out;
  logic                      overflow;

  int seed   = 92;
  int checks = 0;
  int errors = 0;

  ntm_scalar_fixed_unit u_dut (
    .CLK          (CLK),
    .RST          (RST),
    .START        (start),
    .OPERATION    (operation),
    .DATA_A_IN    (data_a),
    .DATA_B_IN    (data_b),
    .READY        (ready),
    .BUSY         (busy),
    .DATA_OUT     (data_out),
    .OVERFLOW_OUT (overflow)
  );

  // 4 ns period
  always #2 CLK = ~CLK;

  //////////////////////////////////////////////////////////////////////
  // Reference model and compare tasks
  //////////////////////////////////////////////////////////////////////

  // Exact math in 64 bits, then clamp to the Q range
  task automatic expected_result(
    input  ntm_arithmetic_pkg::op_e   op,
    input  ntm_arithmetic_pkg::data_t a,
    input  ntm_arithmetic_pkg::data_t b,
    output ntm_arithmetic_pkg::data_t res,
    output logic                      ovf
  );
    longint exact;
    if (op == DIV && b == 0) begin
      // Zero divisor answers the positive limit
      res = MAX;
      ovf = 1'b1;
    end else begin
      case (op)
        ADD: exact = longint'(a) + longint'(b);
        SUB: exact = longint'(a) - longint'(b);
        // Floor of the exact product
        MUL: exact = (longint'(a) * longint'(b)) >>> FRAC;
        // Integer division truncates toward zero
        default: exact = (longint'(a) <<< FRAC) / longint'(b);
      endcase
      ovf = (exact > MAX_L) || (exact < MIN_L);
      if (exact > MAX_L) begin
        res = MAX;
      end else if (exact < MIN_L) begin
        res = MIN;
      end else begin
        res = ntm_arithmetic_pkg::data_t'(exact);
      end
    end
  endtask

  task automatic check_data(input string name, input ntm_arithmetic_pkg::data_t exp,
                            input ntm_arithmetic_pkg::data_t act);
    checks++;
    if (exp !== act) begin
      $display("error %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
      $display("error %s: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int first);
    $display("%-10s done, %0d errors", name, errors - first);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Drive and wait
  //////////////////////////////////////////////////////////////////////

  // One cycle START pulse, inputs change 1 ns after the edge
  task automatic issue_job(input ntm_arithmetic_pkg::op_e op,
                           input ntm_arithmetic_pkg::data_t a,
                           input ntm_arithmetic_pkg::data_t b);
    @(posedge CLK);
    #1;
    start     = 1'b1;
    operation = op;
    data_a    = a;
    data_b    = b;
    @(posedge CLK);
    #1;
    start = 1'b0;
  endtask

  task automatic wait_ready(input string name, output logic seen);
    int cycles;
    cycles = 0;
    while (!ready && cycles < TIMEOUT) begin
      @(posedge CLK);
      #1;
      cycles++;
    end
    seen = ready;
    if (!seen) begin
      $display("%s: no READY within %0d cycles of the job", name, TIMEOUT);
      errors++;
    end
  endtask

  task automatic run_and_compare(input string name, input ntm_arithmetic_pkg::op_e op,
                                 input ntm_arithmetic_pkg::data_t a,
                                 input ntm_arithmetic_pkg::data_t b);
    ntm_arithmetic_pkg::data_t exp_d;
    logic                      exp_o;
    logic                      seen;
    expected_result(op, a, b, exp_d, exp_o);
    issue_job(op, a, b);
    wait_ready(name, seen);
    if (seen) begin
      check_data(name, exp_d, data_out);
      check_flag(name, exp_o, overflow);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    int first;
    first = errors;
    check_flag("reset", 1'b0, ready);
    check_flag("reset", 1'b0, busy);
    check_flag("reset", 1'b0, overflow);
    check_data("reset", '0, data_out);
    report_test("reset", first);
  endtask

  task automatic test_add_sub();
    ntm_arithmetic_pkg::data_t a;
    ntm_arithmetic_pkg::data_t b;
    int                        i;
    int                        first;
    first = errors;
    // 1.5 and 2.25
    run_and_compare("add_sub", ADD, 32'sh0001_8000, 32'sh0002_4000);
    run_and_compare("add_sub", SUB, 32'sh0001_8000, 32'sh0002_4000);
    // One ulp past either limit
    run_and_compare("add_sub", ADD, MAX, 32'sh0000_0001);
    run_and_compare("add_sub", SUB, MIN, 32'sh0000_0001);
    run_and_compare("add_sub", SUB, 32'sh0000_0000, MIN);
    for (i = 0; i < 20; i++) begin
      a = $random(seed);
      b = $random(seed);
      run_and_compare("add_sub", i[0] ? SUB : ADD, a, b);
    end
    report_test("add_sub", first);
  endtask

  task automatic test_multiply();
    ntm_arithmetic_pkg::data_t a;
    ntm_arithmetic_pkg::data_t b;
    int                        i;
    int                        first;
    first = errors;
    // 1.5 * 2.0 and -0.5 * 3.25
    run_and_compare("multiply", MUL, 32'sh0001_8000, 32'sh0002_0000);
    run_and_compare("multiply", MUL, -32'sh0000_8000, 32'sh0003_4000);
    // 1.5 ulp on both signs, floor rounds down
    run_and_compare("multiply", MUL, 32'sh0000_0003, 32'sh0000_8000);
    run_and_compare("multiply", MUL, -32'sh0000_0003, 32'sh0000_8000);
    // Saturating products
    run_and_compare("multiply", MUL, 32'sh7FFF_0000, 32'sh0002_0000);
    run_and_compare("multiply", MUL, MIN, 32'sh0002_0000);
    run_and_compare("multiply", MUL, MIN, MIN);
    for (i = 0; i < 8; i++) begin
      a = $random(seed) >>> 12;
      b = $random(seed) >>> 12;
      run_and_compare("multiply", MUL, a, b);
    end
    report_test("multiply", first);
  endtask

  task automatic test_divide();
    ntm_arithmetic_pkg::data_t a;
    ntm_arithmetic_pkg::data_t b;
    int                        i;
    int                        first;
    first = errors;
    // Index bits pick the sign combination
    for (i = 0; i < 12; i++) begin
      a = $random(seed) & 32'h00FF_FFFF;
      b = ($random(seed) & 32'h000F_FFFF) | 32'h1;
      if (i[0]) a = -a;
      if (i[1]) b = -b;
      run_and_compare("divide", DIV, a, b);
    end
    // -7.0 / 2.0 and a result below one ulp
    run_and_compare("divide", DIV, -32'sh0007_0000, 32'sh0002_0000);
    run_and_compare("divide", DIV, 32'sh0000_0001, 32'sh0003_0000);
    // Tiny divisors overflow
    run_and_compare("divide", DIV, 32'sh7FFF_0000, 32'sh0000_0001);
    run_and_compare("divide", DIV, -32'sh7FFF_0000, 32'sh0000_0001);
    // MIN fits exactly over 1.0, not over -1.0
    run_and_compare("divide", DIV, MIN, 32'sh0001_0000);
    run_and_compare("divide", DIV, MIN, -32'sh0001_0000);
    report_test("divide", first);
  endtask

  task automatic test_div_zero();
    int first;
    first = errors;
    run_and_compare("div_zero", DIV, 32'sh0000_0000, 32'sh0000_0000);
    run_and_compare("div_zero", DIV, 32'sh0001_0000, 32'sh0000_0000);
    run_and_compare("div_zero", DIV, -32'sh0005_8000, 32'sh0000_0000);
    run_and_compare("div_zero", DIV, MIN, 32'sh0000_0000);
    run_and_compare("div_zero", DIV, MAX, 32'sh0000_0000);
    report_test("div_zero", first);
  endtask

  task automatic test_busy_drop();
    ntm_arithmetic_pkg::data_t exp_d;
    logic                      exp_o;
    logic                      seen;
    int                        pulses;
    int                        first;
    first = errors;
    // 10.0 / -4.0
    expected_result(DIV, 32'sh000A_0000, -32'sh0004_0000, exp_d, exp_o);
    issue_job(DIV, 32'sh000A_0000, -32'sh0004_0000);
    check_flag("busy_drop", 1'b1, busy);
    // Add lands mid divide and must vanish
    repeat (4) @(posedge CLK);
    issue_job(ADD, 32'sh0100_0000, 32'sh0100_0000);
    wait_ready("busy_drop", seen);
    if (seen) begin
      check_data("busy_drop", exp_d, data_out);
      check_flag("busy_drop", exp_o, overflow);
    end
    // Next jobs start in the cycle after READY
    run_and_compare("busy_drop", DIV, 32'sh0003_0000, 32'sh0002_0000);
    run_and_compare("busy_drop", ADD, 32'sh0003_0000, 32'sh0002_0000);
    // Dropped add must leave no late result behind
    pulses = 0;
    repeat (QUIET) begin
      @(posedge CLK);
      #1;
      if (ready) pulses++;
    end
    if (pulses != 0) begin
      $display("busy_drop: %0d extra READY pulses after the last result", pulses);
      errors++;
    end
    check_flag("busy_drop", 1'b0, busy);
    report_test("busy_drop", first);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    CLK       = 1'b0;
    RST       = 1'b1;
    start     = 1'b0;
    operation = ADD;
    data_a    = '0;
    data_b    = '0;
    repeat (2) @(posedge CLK);
    #1;
    RST = 1'b0;

    test_reset();
    test_add_sub();
    test_multiply();
    test_divide();
    test_div_zero();
    test_busy_drop();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
